// ==== scaler_settings.svh ====
`ifndef SCALER_SETTINGS_SVH
`define SCALER_SETTINGS_SVH

// bank geometry
`define SCALER_CHANNELS 32
`define SCALER_COUNT_BITS 16

// wishbone port widths, byte addressed
`define SCALER_ADDR_BITS 8
`define SCALER_DATA_BITS 32

// level-two strobes land on the upper channels of the second bank
`define SCALER_L2_BITS 24
`define SCALER_L2_OFFSET 8

// gate selection
`define SCALER_GATE_SEL_BITS 3
`define SCALER_GP_GATE_BITS 6

// control block word map
`define SCALER_CTRL_WORD_BITS 3
`define SCALER_REG_GATE_SEL 3'd0
`define SCALER_REG_GATE_EN 3'd1
`define SCALER_REG_SECONDS 3'd2

`endif

// ==== scaler_pkg.sv ====
`default_nettype none

`include "scaler_settings.svh"

package scaler_pkg;

    typedef logic [`SCALER_ADDR_BITS-1:0] wb_addr_t;
    typedef logic [`SCALER_DATA_BITS-1:0] wb_data_t;
    typedef logic [`SCALER_COUNT_BITS-1:0] scaler_count_t;

    // one bit per channel, used for strobes and gate enables
    typedef logic [`SCALER_CHANNELS-1:0] chan_mask_t;
    typedef logic [$clog2(`SCALER_CHANNELS)-1:0] chan_index_t;
    typedef logic [`SCALER_GATE_SEL_BITS-1:0] gate_sel_t;

    // master to slave
    typedef struct packed {
        logic                           cyc;
        logic                           stb;
        logic                           we;
        logic [`SCALER_DATA_BITS/8-1:0] sel;
        wb_addr_t                       adr;
        wb_data_t                       dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== scaler_ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scaler_settings.svh"

module scaler_ctrl_regs (
    input  wire                             wb_clk_i,
    input  wire                             reset_i,
    input  wire                             wr_stb_i,
    input  wire [`SCALER_CTRL_WORD_BITS-1:0] reg_word_i,
    input  wire scaler_pkg::wb_data_t       wr_dat_i,
    output scaler_pkg::wb_data_t            rd_dat_o,
    input  wire                             pps_i,
    input  wire [`SCALER_GP_GATE_BITS-1:0]  gp_gate_i,
    output logic                            gate_o,
    output scaler_pkg::chan_mask_t          gate_en_o
);

    scaler_pkg::gate_sel_t  gate_sel_q;
    scaler_pkg::chan_mask_t gate_en_q;
    scaler_pkg::wb_data_t   seconds_q;
    scaler_pkg::gate_sel_t  gp_idx;

    // register writes and the pps counter
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            gate_sel_q <= '0;
            gate_en_q  <= '0;
            seconds_q  <= '0;
        end else begin
            if (wr_stb_i) begin
                case (reg_word_i)
                    `SCALER_REG_GATE_SEL: begin
                        gate_sel_q <= wr_dat_i[`SCALER_GATE_SEL_BITS-1:0];
                    end
                    `SCALER_REG_GATE_EN: begin
                        gate_en_q <= wr_dat_i;
                    end
                    default: begin
                        // seconds count and unused words are read-only
                    end
                endcase
            end
            if (pps_i) begin
                seconds_q <= seconds_q + 1'b1;
            end
        end
    end

    // codes 1..6 pick gp_gate_i bits 0..5
    assign gp_idx = gate_sel_q - 1'b1;

    always_comb begin
        case (gate_sel_q)
            3'd0:    gate_o = 1'b1;
            3'd7:    gate_o = 1'b0;
            default: gate_o = gp_gate_i[gp_idx];
        endcase
    end

    assign gate_en_o = gate_en_q;

    // combinational readback, the wrapper registers it
    always_comb begin
        case (reg_word_i)
            `SCALER_REG_GATE_SEL: begin
                rd_dat_o = scaler_pkg::wb_data_t'(gate_sel_q);
            end
            `SCALER_REG_GATE_EN: begin
                rd_dat_o = gate_en_q;
            end
            `SCALER_REG_SECONDS: begin
                rd_dat_o = seconds_q;
            end
            default: begin
                rd_dat_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== scaler_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scaler_settings.svh"

module scaler_core (
    input  wire                         wb_clk_i,
    input  wire                         reset_i,
    input  wire scaler_pkg::chan_index_t rd_word_i,
    output scaler_pkg::scaler_count_t   rd_dat_o,
    input  wire                         pps_i,
    input  wire                         gate_i,
    input  wire scaler_pkg::chan_mask_t gate_en_i,
    input  wire scaler_pkg::chan_mask_t trig_i
);

    // live counts and the copies taken at the last second strobe
    scaler_pkg::scaler_count_t running_q [`SCALER_CHANNELS];
    scaler_pkg::scaler_count_t latched_q [`SCALER_CHANNELS];
    scaler_pkg::chan_mask_t    hit;

    // holds at full scale instead of wrapping
    function automatic scaler_pkg::scaler_count_t sat_inc(
        input scaler_pkg::scaler_count_t cnt
    );
        scaler_pkg::scaler_count_t res;
        if (cnt == '1) begin
            res = cnt;
        end else begin
            res = cnt + 1'b1;
        end
        return res;
    endfunction

    // enabled channels only count while the gate is open,
    // the others count every strobe
    assign hit = trig_i & (~gate_en_i | {`SCALER_CHANNELS{gate_i}});

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `SCALER_CHANNELS; i++) begin
                running_q[i] <= '0;
                latched_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `SCALER_CHANNELS; i++) begin
                if (pps_i) begin
                    // snapshot excludes this cycle's strobe,
                    // which starts the new second instead
                    latched_q[i] <= running_q[i];
                    running_q[i] <= scaler_pkg::scaler_count_t'(hit[i]);
                end else if (hit[i]) begin
                    running_q[i] <= sat_inc(running_q[i]);
                end
            end
        end
    end

    // read port is combinational
    assign rd_dat_o = latched_q[rd_word_i];

endmodule

`default_nettype wire

// ==== scaler_wrap.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scaler_settings.svh"

module scaler_wrap (
    input  wire                            wb_clk_i,
    input  wire                            reset_i,
    input  wire scaler_pkg::wb_req_t       wb_req_i,
    output scaler_pkg::wb_rsp_t            wb_rsp_o,
    input  wire                            pps_i,
    input  wire [`SCALER_GP_GATE_BITS-1:0] gp_gate_i,
    input  wire scaler_pkg::chan_mask_t    trig_i,
    input  wire [`SCALER_L2_BITS-1:0]      leveltwo_i
);

    logic                              strobe;
    logic                              sel_main;
    logic                              sel_ctrl;
    logic                              ctrl_wr;
    scaler_pkg::chan_index_t           bank_word;
    logic [`SCALER_CTRL_WORD_BITS-1:0] ctrl_word;
    scaler_pkg::wb_data_t              ctrl_dat;
    scaler_pkg::scaler_count_t         main_dat;
    scaler_pkg::scaler_count_t         l2_dat;
    scaler_pkg::wb_data_t              rd_mux;
    scaler_pkg::wb_data_t              dat_q;
    scaler_pkg::chan_mask_t            l2_trig;
    scaler_pkg::chan_mask_t            gate_en;
    logic                              gate;
    logic                              ack_q;

    assign strobe = wb_req_i.cyc && wb_req_i.stb;

    // bit 7 low is the main bank; bit 7 high splits on bits 6..5,
    // zero there is the control block, anything else the level-two bank
    assign sel_main = !wb_req_i.adr[7];
    assign sel_ctrl = wb_req_i.adr[7] && (wb_req_i.adr[6:5] == 2'b00);

    assign bank_word = wb_req_i.adr[2 +: $bits(scaler_pkg::chan_index_t)];
    assign ctrl_word = wb_req_i.adr[2 +: `SCALER_CTRL_WORD_BITS];

    // bank writes are acked but go nowhere
    assign ctrl_wr = strobe && wb_req_i.we && sel_ctrl;

    // lowest eight level-two channels have no input
    assign l2_trig = {leveltwo_i, {`SCALER_L2_OFFSET{1'b0}}};

    scaler_ctrl_regs u_ctrl (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .wr_stb_i   (ctrl_wr),
        .reg_word_i (ctrl_word),
        .wr_dat_i   (wb_req_i.dat),
        .rd_dat_o   (ctrl_dat),
        .pps_i      (pps_i),
        .gp_gate_i  (gp_gate_i),
        .gate_o     (gate),
        .gate_en_o  (gate_en)
    );

    scaler_core u_main_core (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .rd_word_i  (bank_word),
        .rd_dat_o   (main_dat),
        .pps_i      (pps_i),
        .gate_i     (gate),
        .gate_en_i  (gate_en),
        .trig_i     (trig_i)
    );

    scaler_core u_l2_core (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .rd_word_i  (bank_word),
        .rd_dat_o   (l2_dat),
        .pps_i      (pps_i),
        .gate_i     (gate),
        .gate_en_i  (gate_en),
        .trig_i     (l2_trig)
    );

    // counts sit in the low half of the word
    always_comb begin
        if (sel_main) begin
            rd_mux = scaler_pkg::wb_data_t'(main_dat);
        end else if (sel_ctrl) begin
            rd_mux = ctrl_dat;
        end else begin
            rd_mux = scaler_pkg::wb_data_t'(l2_dat);
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= strobe;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (strobe) begin
            dat_q <= rd_mux;
        end
    end

    // ack is dropped if the master abandons the cycle
    assign wb_rsp_o = '{ack: ack_q && wb_req_i.cyc, dat: dat_q};

endmodule

`default_nettype wire

// ==== scaler_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module scaler_checker (
    input  wire                       wb_clk_i,
    input  wire                       reset_i,
    input  wire scaler_pkg::wb_req_t  wb_req_i,
    input  wire scaler_pkg::wb_rsp_t  wb_rsp_i,
    input  wire                       exp_chk_i,
    input  wire scaler_pkg::wb_data_t exp_dat_i,
    output logic [31:0]               err_count_o,
    output logic [31:0]               read_count_o
);

    logic                 strobe_q;
    logic                 rd_pend_q;
    logic                 rd_chk_q;
    scaler_pkg::wb_addr_t adr_q;
    scaler_pkg::wb_data_t exp_q;

    // counter banks are everything outside 0x80..0x9f
    function automatic logic is_bank(input scaler_pkg::wb_addr_t adr);
        return (adr < 8'h80) || (adr > 8'h9f);
    endfunction

    // sampled on the rising edge, the driver only moves on falling edges
    always @(posedge wb_clk_i) begin : compare
        logic        strobe;
        logic        ack_exp;
        logic [31:0] errs;
        logic [31:0] reads;
        strobe = wb_req_i.cyc && wb_req_i.stb;
        ack_exp = strobe_q && wb_req_i.cyc;
        errs = '0;
        reads = '0;
        if (reset_i) begin
            strobe_q <= 1'b0;
            rd_pend_q <= 1'b0;
            err_count_o <= '0;
            read_count_o <= '0;
        end else begin
            if (wb_rsp_i.ack !== ack_exp) begin
                $display("FAILED at %0t: ack is %b where %b was expected",
                         $time, wb_rsp_i.ack, ack_exp);
                errs = errs + 32'd1;
            end
            if (rd_pend_q && rd_chk_q && wb_rsp_i.ack) begin
                reads = 32'd1;
                if (wb_rsp_i.dat !== exp_q) begin
                    $display("FAILED at %0t: read of 0x%02h gave 0x%08h, expected 0x%08h",
                             $time, adr_q, wb_rsp_i.dat, exp_q);
                    errs = errs + 32'd1;
                end
                // counts only fill the low half
                if (is_bank(adr_q) && wb_rsp_i.dat[31:16] !== 16'h0000) begin
                    $display("FAILED at %0t: bank read of 0x%02h has 0x%04h in the upper half",
                             $time, adr_q, wb_rsp_i.dat[31:16]);
                    errs = errs + 32'd1;
                end
            end
            strobe_q <= strobe;
            rd_pend_q <= strobe && !wb_req_i.we;
            rd_chk_q <= exp_chk_i;
            adr_q <= wb_req_i.adr;
            exp_q <= exp_dat_i;
            err_count_o <= err_count_o + errs;
            read_count_o <= read_count_o + reads;
        end
    end

endmodule

`default_nettype wire

// ==== tb_scaler.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "scaler_settings.svh"

module tb_scaler;

    logic                            wb_clk;
    logic                            reset;
    scaler_pkg::wb_req_t             wb_req;
    scaler_pkg::wb_rsp_t             wb_rsp;
    logic                            pps;
    logic [`SCALER_GP_GATE_BITS-1:0] gp_gate;
    scaler_pkg::chan_mask_t          trig;
    logic [`SCALER_L2_BITS-1:0]      leveltwo;
    logic                            exp_chk;
    scaler_pkg::wb_data_t            exp_dat;
    logic [31:0]                     chk_errs;
    logic [31:0]                     chk_reads;
    logic [31:0]                     lfsr_q;
    int                              tb_errs;
    int                              cycle_limit;
    int                              cycles;
    int                              tests;

    scaler_wrap DUT (
        .wb_clk_i   (wb_clk),
        .reset_i    (reset),
        .wb_req_i   (wb_req),
        .wb_rsp_o   (wb_rsp),
        .pps_i      (pps),
        .gp_gate_i  (gp_gate),
        .trig_i     (trig),
        .leveltwo_i (leveltwo)
    );

    scaler_checker u_check (
        .wb_clk_i     (wb_clk),
        .reset_i      (reset),
        .wb_req_i     (wb_req),
        .wb_rsp_i     (wb_rsp),
        .exp_chk_i    (exp_chk),
        .exp_dat_i    (exp_dat),
        .err_count_o  (chk_errs),
        .read_count_o (chk_reads)
    );

    initial begin
        wb_clk = 1'b0;
        forever begin
            #2 wb_clk = ~wb_clk;
        end
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_bit(output logic b);
        b = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
    endtask

    // one wishbone transfer, then a random gap of 0..3 idle cycles
    task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat);
        logic got_ack;
        logic b1;
        logic b0;
        int   waited;
        @(negedge wb_clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we = we;
        wb_req.sel = 4'hf;
        wb_req.adr = adr[7:0];
        wb_req.dat = we ? dat : '0;
        exp_chk = !we;
        exp_dat = dat;
        got_ack = 1'b0;
        waited = 0;
        while (!got_ack && waited < 8) begin
            @(negedge wb_clk);
            got_ack = wb_rsp.ack;
            waited++;
        end
        if (!got_ack) begin
            $display("no acknowledge came for the access to address 0x%02h", adr[7:0]);
            tb_errs++;
        end
        // stb drops at once, cyc stays up through the acked cycle
        wb_req.stb = 1'b0;
        @(negedge wb_clk);
        wb_req.cyc = 1'b0;
        wb_req.we = 1'b0;
        exp_chk = 1'b0;
        take_bit(b1);
        take_bit(b0);
        repeat ({b1, b0}) begin
            @(negedge wb_clk);
        end
    endtask

    // every word of all three regions reads zero straight out of reset
    task automatic sweep_reset_reads();
        for (int w = 0; w < 64; w++) begin
            bus_access(1'b0, w * 4, 32'h0000_0000);
        end
        finish_test("reset_sweep", 0, 0);
    endtask

    task automatic hold_mask(input logic is_l2, input logic [31:0] mask, input int n);
        @(negedge wb_clk);
        if (is_l2) begin
            leveltwo = mask[`SCALER_L2_BITS-1:0];
        end else begin
            trig = mask;
        end
        repeat (n) begin
            @(negedge wb_clk);
        end
        trig = '0;
        leveltwo = '0;
    endtask

    function automatic string test_name_of(input string line);
        int last;
        last = line.len() - 1;
        while (last > 2 && (line.getc(last) == "\n" || line.getc(last) == " ")) begin
            last--;
        end
        return line.substr(2, last);
    endfunction

    task automatic finish_test(input string name, input int err_base, input int read_base);
        int errs;
        errs = tb_errs + int'(chk_errs) - err_base;
        $display("test %s: %0d reads checked, %0d errors", name, int'(chk_reads) - read_base, errs);
        tests++;
    endtask

    // line count times 64 plus every cycle count in the script
    task automatic compute_limit(output int limit);
        int          fd;
        int          lines;
        int          n;
        string       line;
        byte         op;
        logic [31:0] a;
        limit = 0;
        lines = 0;
        fd = $fopen("scaler_input.txt", "r");
        if (fd == 0) begin
            return;
        end
        while ($fgets(line, fd) != 0) begin
            lines++;
            op = line.getc(0);
            n = 0;
            if (op == "T" || op == "L") begin
                void'($sscanf(line, "%c %h %d", op, a, n));
            end else if (op == "I") begin
                void'($sscanf(line, "%c %d", op, n));
            end
            limit += n;
        end
        $fclose(fd);
        limit += lines * 64;
    endtask

    task automatic run_script();
        int          fd;
        int          n;
        int          err_base;
        int          read_base;
        string       line;
        string       name;
        byte         op;
        logic [31:0] a;
        logic [31:0] b;
        name = "";
        err_base = 0;
        read_base = 0;
        fd = $fopen("scaler_input.txt", "r");
        if (fd == 0) begin
            $display("could not open scaler_input.txt");
            tb_errs++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            op = line.getc(0);
            case (op)
                "N": begin
                    if (name != "") begin
                        finish_test(name, err_base, read_base);
                    end
                    name = test_name_of(line);
                    err_base = tb_errs + int'(chk_errs);
                    read_base = int'(chk_reads);
                end
                "W", "R": begin
                    void'($sscanf(line, "%c %h %h", op, a, b));
                    bus_access(op == "W", a, b);
                end
                "T", "L": begin
                    void'($sscanf(line, "%c %h %d", op, a, n));
                    hold_mask(op == "L", a, n);
                end
                "G": begin
                    void'($sscanf(line, "%c %h", op, a));
                    @(negedge wb_clk);
                    gp_gate = a[`SCALER_GP_GATE_BITS-1:0];
                end
                "P": begin
                    @(negedge wb_clk);
                    pps = 1'b1;
                    @(negedge wb_clk);
                    pps = 1'b0;
                end
                "I": begin
                    void'($sscanf(line, "%c %d", op, n));
                    repeat (n) begin
                        @(negedge wb_clk);
                    end
                end
                "#", "\n", "\r": begin
                end
                default: begin
                    $display("unknown line in scaler_input.txt: %s", line);
                    tb_errs++;
                end
            endcase
        end
        $fclose(fd);
        if (name != "") begin
            finish_test(name, err_base, read_base);
        end
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        reset = 1'b1;
        wb_req = '0;
        pps = 1'b0;
        gp_gate = '0;
        trig = '0;
        leveltwo = '0;
        exp_chk = 1'b0;
        exp_dat = '0;
        lfsr_q = 32'h71e1_530c;
        tb_errs = 0;
        tests = 0;
        compute_limit(cycle_limit);
        repeat (4) begin
            @(negedge wb_clk);
        end
        reset = 1'b0;
        sweep_reset_reads();
        run_script();
        repeat (2) begin
            @(negedge wb_clk);
        end
        $display("%0d tests, %0d reads checked, %0d errors", tests, chk_reads,
                 tb_errs + int'(chk_errs));
        if (tb_errs == 0 && chk_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog, armed once the script length is known
    initial begin
        cycles = 0;
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge wb_clk);
            cycles++;
        end
        $display("run stopped after %0d cycles before the script was done", cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== scaler_input.txt ====
# op a b: W addr data, R addr expected, T/L mask cycles, G gp_gate, P pps, I cycles
# addresses, data and masks in hex, cycle counts in decimal, N starts a named test
N reset
R 00 00000000
R fc 00000000
R 88 00000000
W 80 00000005
W 84 a5a5f00f
W 10 12345678
R 80 00000005
R 84 a5a5f00f
R 10 00000000
W 84 00000000
N main_latch
T 00000001 5
T 00000006 3
I 3
T 80000003 2
P
R 00 00000007
R 04 00000005
R 08 00000003
R 7c 00000002
P
R 00 00000000
N level_two
L 800001 4
L 000400 3
P
R a0 00000004
R fc 00000004
R c8 00000003
R 20 00000000
N gating
W 84 0000000f
W 80 00000007
T 000000ff 4
P
R 0c 00000000
R 10 00000004
W 80 00000003
G 04
T 00000011 5
G 3b
T 00000011 3
P
R 00 00000005
R 10 00000008
R 88 00000005
W 84 00000000
W 80 00000000
N saturate
T 00000300 65536
T 00000100 4464
P
R 20 0000ffff
R 24 0000ffff
R 88 00000006

// ==== src.f ====
+incdir+.
scaler_pkg.sv
scaler_ctrl_regs.sv
scaler_core.sv
scaler_wrap.sv
scaler_checker.sv
tb_scaler.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_scaler -f src.f -o sim_scaler || exit 1
out="$(./obj_dir/sim_scaler)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Simulation PASSED" && echo "scaler run passed" || { echo "scaler run failed"; exit 1; }
